//--- md_core_pkg.sv
/*
 * console core package
 * bridge setting map, cartridge header offsets, region, gun, quirk and pad types
 */
package md_core_pkg;

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // bridge setting registers
    typedef enum bridge_addr_t {
        addr_multitap  = 32'h0000_0000,
        addr_aspect    = 32'h0000_0010,
        addr_composite = 32'h0000_0020,
        addr_obj_limit = 32'h0000_0030,
        addr_fm        = 32'h0000_0040,
        addr_psg       = 32'h0000_0050,
        addr_hifi_pcm  = 32'h0000_0060,
        addr_reset     = 32'h0000_0070,
        addr_m30_map   = 32'h0000_0080,
        addr_fm_chip   = 32'h00A0_0000,
        addr_turbo     = 32'h00C0_0000,
        addr_region    = 32'h00E0_0000,  // read only
        addr_filter    = 32'h00F0_0000
    } setting_addr_e;

    //////////////////////////////
    // cartridge header

    typedef logic [24:0] rom_addr_t;
    typedef logic [15:0] rom_word_t;  // high byte comes first in the image

    localparam rom_addr_t HDR_ID_FIRST = 25'h182;
    localparam rom_addr_t HDR_ID_LAST  = 25'h18A;
    localparam rom_addr_t HDR_ID_CHECK = 25'h18C;  // word after the id
    localparam rom_addr_t HDR_REGION_A = 25'h1F0;
    localparam rom_addr_t HDR_REGION_B = 25'h1F2;
    localparam rom_addr_t HDR_END      = 25'h200;

    typedef enum logic [1:0] {jp = 2'd0, us = 2'd1, eu = 2'd2} region_e;

    typedef enum logic {menacer = 1'b0, justifier = 1'b1} gun_type_e;
    typedef logic [7:0] gun_delay_t;
    localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

    typedef enum logic [3:0] {
        sram, sram00, eeprom, noram, fifo, pier, svp, fmbusy, schan
    } quirk_e;
    localparam int QUIRK_W = 9;
    typedef logic [QUIRK_W-1:0] quirk_flags_t;

    //////////////////////////////
    // controllers and reset

    typedef logic [15:0] key_map_t;
    typedef logic [11:0] pad_t;  // Z Y X mode start B C A up down left right
    localparam int NUM_PADS = 4;

    localparam int RESET_CNT_W   = 12;
    localparam int RESET_DELAY_W = RESET_CNT_W + 4;

endpackage

//--- core_settings.sv
/*
 * core settings register file
 * decodes bridge writes into the core settings, runs the reset delay
 * and returns the detected region on bridge reads
 */
module core_settings (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,
    input  md_core_pkg::bridge_addr_t bridge_addr,
    input  logic                      bridge_wr,
    input  md_core_pkg::bridge_data_t bridge_wr_data,
    output md_core_pkg::bridge_data_t bridge_rd_data,
    input  logic                      osnotify_inmenu,
    input  md_core_pkg::region_e      region_req,
    output logic [1:0]                cpu_turbo,
    output logic                      multitap_en,
    output logic                      ar_correction_en,
    output logic                      composite_en,
    output logic                      obj_limit_high_en,
    output logic                      fm_en,
    output logic                      psg_en,
    output logic                      hifi_pcm_en,
    output logic [1:0]                audio_filter,
    output logic                      fm_chip,
    output logic                      m30_map,
    output logic                      reset_hold
);
    import md_core_pkg::*;

    logic [RESET_CNT_W-1:0]   reset_counter;  // free running, seeds the delay
    logic [RESET_DELAY_W-1:0] reset_delay;

    //////////////////////////////
    // setting registers

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            cpu_turbo         <= 2'd0;
            multitap_en       <= 1'b0;
            ar_correction_en  <= 1'b0;
            composite_en      <= 1'b0;
            obj_limit_high_en <= 1'b1;
            fm_en             <= 1'b1;
            psg_en            <= 1'b1;
            hifi_pcm_en       <= 1'b1;
            audio_filter      <= 2'd0;
            fm_chip           <= 1'b0;
            m30_map           <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                addr_turbo:     cpu_turbo         <= bridge_wr_data[1:0];
                addr_multitap:  multitap_en       <= bridge_wr_data[0];
                addr_aspect:    ar_correction_en  <= bridge_wr_data[0];
                addr_composite: composite_en      <= bridge_wr_data[0];
                addr_obj_limit: obj_limit_high_en <= bridge_wr_data[0];
                addr_fm:        fm_en             <= bridge_wr_data[0];
                addr_psg:       psg_en            <= bridge_wr_data[0];
                addr_hifi_pcm:  hifi_pcm_en       <= bridge_wr_data[0];
                addr_filter:    audio_filter      <= bridge_wr_data[1:0];
                addr_fm_chip:   fm_chip           <= bridge_wr_data[0];
                addr_m30_map:   m30_map           <= bridge_wr_data[0];
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // reset delay

    // pseudo random hold length, frozen while the menu is up
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            reset_counter <= '0;
            reset_delay   <= '0;
        end else begin
            reset_counter <= reset_counter + 1'b1;
            if (bridge_wr && bridge_addr == addr_reset && bridge_wr_data != '0)
                reset_delay <= {reset_counter, 4'hf};
            else if (!osnotify_inmenu && reset_delay != '0)
                reset_delay <= reset_delay - 1'b1;
        end
    end

    assign reset_hold = (reset_delay != '0);

    // only the region is readable, everything else reads zero
    assign bridge_rd_data = (bridge_addr == addr_region) ? bridge_data_t'(region_req) : '0;

endmodule

//--- cart_region_detect.sv
/*
 * cartridge region detect
 * decodes the region characters of the ROM header while the image loads
 * and requests a region once the header is complete
 */
module cart_region_detect (
    input  logic                   clk_74a,
    input  logic                   pll_core_locked,
    input  logic                   cart_loading,
    input  logic                   rom_wr,
    input  md_core_pkg::rom_addr_t rom_addr,
    input  md_core_pkg::rom_word_t rom_data,
    output md_core_pkg::region_e   region_req,
    output logic                   region_set
);
    import md_core_pkg::*;

    logic       hdr_wr;
    logic       loading_q;
    logic       hdr_ready;
    logic       hdr_ready_q;
    logic [2:0] hdr_flags;  // {e, u, j}
    logic [2:0] lo_letter;
    logic [2:0] hi_letter;
    logic [2:0] lo_code;
    logic [3:0] hex_adj;
    logic       lo_digit;
    logic       lo_hex;

    function automatic logic [2:0] letter_flags(input logic [7:0] c);
        case (c)
            "J":     return 3'b001;
            "U":     return 3'b010;
            "E":     return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    assign hdr_wr    = rom_wr & cart_loading;
    assign lo_letter = letter_flags(rom_data[7:0]);
    assign hi_letter = letter_flags(rom_data[15:8]);
    assign hex_adj   = rom_data[3:0] - 4'd7;  // 'A'..'F' back to 10..15
    assign lo_digit  = (rom_data[7:0] >= "0") && (rom_data[7:0] <= "9");
    assign lo_hex    = (rom_data[7:0] >= "A") && (rom_data[7:0] <= "F");

    // newer carts carry a hex code, bits map to e/u/j
    always_comb begin
        if (lo_digit)
            lo_code = {rom_data[3], rom_data[2], rom_data[0]};
        else
            lo_code = {hex_adj[3], hex_adj[2], hex_adj[0]};
    end

    //////////////////////////////
    // header flags

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            loading_q <= 1'b0;
            hdr_ready <= 1'b0;
            hdr_flags <= 3'b000;
        end else begin
            loading_q <= cart_loading;

            if (cart_loading && !loading_q) begin
                hdr_flags <= 3'b000;  // new image
            end else if (hdr_wr && rom_addr == HDR_REGION_A) begin
                if (lo_letter == 3'b000 && (lo_digit || lo_hex))
                    hdr_flags <= lo_code | hi_letter;
                else
                    hdr_flags <= hdr_flags | lo_letter | hi_letter;
            end else if (hdr_wr && rom_addr == HDR_REGION_B) begin
                hdr_flags <= hdr_flags | lo_letter;
            end

            if (!cart_loading && loading_q)
                hdr_ready <= 1'b0;
            else if (hdr_wr && rom_addr == HDR_END)
                hdr_ready <= 1'b1;
        end
    end

    //////////////////////////////
    // region request

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hdr_ready_q <= 1'b0;
            region_set  <= 1'b0;
            region_req  <= jp;
        end else begin
            hdr_ready_q <= hdr_ready;
            if (hdr_ready && !hdr_ready_q) begin
                region_set <= 1'b1;
                if (hdr_flags[1])
                    region_req <= us;
                else if (hdr_flags[2])
                    region_req <= eu;
                else if (hdr_flags[0])
                    region_req <= jp;
                else
                    region_req <= us;  // no marking at all
            end else if (!hdr_ready && hdr_ready_q) begin
                region_set <= 1'b0;
            end
        end
    end

endmodule

//--- cart_quirk_lookup.sv
/*
 * cartridge quirk lookup
 * captures the product id from the ROM header and matches it against
 * the compatibility table for quirk flags and light gun timing
 */
module cart_quirk_lookup (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,
    input  logic                      cart_loading,
    input  logic                      rom_wr,
    input  md_core_pkg::rom_addr_t    rom_addr,
    input  md_core_pkg::rom_word_t    rom_data,
    output md_core_pkg::quirk_flags_t quirks,
    output md_core_pkg::gun_type_e    gun_type,
    output md_core_pkg::gun_delay_t   gun_delay
);
    import md_core_pkg::*;

    logic         id_wr;
    logic [63:0]  cart_id;  // 8 ascii characters
    quirk_flags_t quirk_q;
    quirk_flags_t hit_quirks;
    gun_type_e    hit_gun;
    gun_delay_t   hit_delay;

    assign id_wr = rom_wr & cart_loading;

    // id words arrive byte swapped
    always_ff @(posedge clk_74a) begin
        if (id_wr) begin
            case (rom_addr)
                HDR_ID_FIRST:         cart_id[63:56] <= rom_data[15:8];
                HDR_ID_FIRST + 25'd2: cart_id[55:40] <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID_FIRST + 25'd4: cart_id[39:24] <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID_FIRST + 25'd6: cart_id[23:8]  <= {rom_data[7:0], rom_data[15:8]};
                HDR_ID_LAST:          cart_id[7:0]   <= rom_data[7:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // compatibility table

    always_comb begin
        hit_quirks = '0;
        case (cart_id)
            "T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
                hit_quirks[sram] = 1'b1;
            "MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
            "00004076", "T-12046 ", "T-12053 ", "G-4524  ":
                hit_quirks[eeprom] = 1'b1;
            "T-113016":             hit_quirks[noram]  = 1'b1;  // fake ram check
            "T-89016 ":             hit_quirks[fifo]   = 1'b1;
            "T-574023", "T-574013": hit_quirks[pier]   = 1'b1;
            "MK-1229 ", "G-7001  ": hit_quirks[svp]    = 1'b1;  // virtua racing
            "T-35036 ", "T-25073 ", "MK-1137-":
                hit_quirks[fmbusy] = 1'b1;
            "T-68???-":             hit_quirks[schan]  = 1'b1;
            " GM 0000":             hit_quirks[sram00] = 1'b1;
            default: ;
        endcase
    end

    // light gun device and sensor offset
    always_comb begin
        hit_gun   = menacer;
        hit_delay = GUN_DELAY_DEFAULT;
        case (cart_id)
            "MK-1533 ": hit_delay = 8'd100;
            "T-95096-": begin
                hit_gun   = justifier;
                hit_delay = 8'd52;
            end
            "T-95136-": begin
                hit_gun   = justifier;  // lethal enforcers ii
                hit_delay = 8'd30;
            end
            "MK-1658 ": hit_delay = 8'd120;
            "T-081156": hit_delay = 8'd126;
            default: ;
        endcase
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            quirk_q   <= '0;
            gun_type  <= menacer;
            gun_delay <= GUN_DELAY_DEFAULT;
        end else if (id_wr && rom_addr == HDR_ID_CHECK) begin
            quirk_q   <= hit_quirks;
            gun_type  <= hit_gun;
            gun_delay <= hit_delay;
        end
    end

    // system sees no quirks while an image streams in
    assign quirks = cart_loading ? '0 : quirk_q;

endmodule

//--- pad_mapper.sv
/*
 * controller mapping
 * synchronizes the host key bitmaps and remaps them to console pad order
 */
module pad_mapper (
    input  logic                  clk_74a,
    input  logic                  pll_core_locked,
    input  md_core_pkg::key_map_t cont_key [md_core_pkg::NUM_PADS],
    input  logic                  m30_map,
    output md_core_pkg::pad_t     joy [md_core_pkg::NUM_PADS]
);
    import md_core_pkg::*;

    key_map_t key_meta [NUM_PADS];
    key_map_t key_sync [NUM_PADS];

    // host bits: 0-3 dpad, 4 a, 5 b, 6 x, 7 y, 8 l1, 9 r1, 10 l2, 11 r2, 14 select, 15 start
    function automatic pad_t map_keys(input key_map_t k, input logic m30);
        return {
            m30 ? k[10] : k[9],  // Z
            m30 ? k[7]  : k[6],  // Y
            m30 ? k[6]  : k[8],  // X
            k[14],               // mode
            k[15],
            m30 ? k[11] : k[4],  // B
            k[5],                // C, same in both layouts
            m30 ? k[4]  : k[7],  // A
            k[0], k[1], k[2], k[3]
        };
    endfunction

    // two stage sync, keys come from another clock
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                key_meta[i] <= '0;
                key_sync[i] <= '0;
            end
        end else begin
            key_meta <= cont_key;
            key_sync <= key_meta;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_PADS; i++)
            joy[i] = map_keys(key_sync[i], m30_map);
    end

endmodule

//--- md_core_top.sv
/*
 * console core top, bridge clock domain
 * settings, cartridge header inspection and controller mapping,
 * plus the system reset combination
 */
module md_core_top (
    input  logic                      clk_74a,
    input  logic                      pll_core_locked,
    input  md_core_pkg::bridge_addr_t bridge_addr,
    input  logic                      bridge_wr,
    input  md_core_pkg::bridge_data_t bridge_wr_data,
    output md_core_pkg::bridge_data_t bridge_rd_data,
    input  logic                      osnotify_inmenu,
    input  logic                      cart_loading,
    input  logic                      rom_wr,
    input  md_core_pkg::rom_addr_t    rom_addr,
    input  md_core_pkg::rom_word_t    rom_data,
    input  md_core_pkg::key_map_t     cont_key [md_core_pkg::NUM_PADS],
    output md_core_pkg::pad_t         joy [md_core_pkg::NUM_PADS],
    output logic [1:0]                cpu_turbo,
    output logic                      multitap_en,
    output logic                      ar_correction_en,
    output logic                      composite_en,
    output logic                      obj_limit_high_en,
    output logic                      fm_en,
    output logic                      psg_en,
    output logic                      hifi_pcm_en,
    output logic [1:0]                audio_filter,
    output logic                      fm_chip,
    output md_core_pkg::quirk_flags_t quirks,
    output md_core_pkg::gun_type_e    gun_type,
    output md_core_pkg::gun_delay_t   gun_delay,
    output md_core_pkg::region_e      region_req,
    output logic                      system_reset_n
);

    logic m30_map;
    logic reset_hold;
    logic region_set;

    //////////////////////////////
    // settings and bridge readback

    core_settings settings0 (
        .clk_74a, .pll_core_locked,
        .bridge_addr, .bridge_wr, .bridge_wr_data, .bridge_rd_data,
        .osnotify_inmenu, .region_req,
        .cpu_turbo, .multitap_en, .ar_correction_en, .composite_en,
        .obj_limit_high_en, .fm_en, .psg_en, .hifi_pcm_en,
        .audio_filter, .fm_chip, .m30_map, .reset_hold
    );

    //////////////////////////////
    // cartridge header

    cart_region_detect region0 (
        .clk_74a, .pll_core_locked,
        .cart_loading, .rom_wr, .rom_addr, .rom_data,
        .region_req, .region_set
    );

    cart_quirk_lookup quirk0 (
        .clk_74a, .pll_core_locked,
        .cart_loading, .rom_wr, .rom_addr, .rom_data,
        .quirks, .gun_type, .gun_delay
    );

    pad_mapper pads0 (
        .clk_74a, .pll_core_locked,
        .cont_key, .m30_map, .joy
    );

    // system held in reset for chip reset, delay request or region change
    assign system_reset_n = pll_core_locked & ~reset_hold & ~region_set;

endmodule

//--- md_core_chk.sv
/*
 * console core checker
 * concurrent assertions on reset, quirk, region and bridge readback rules
 */
module md_core_chk (
    input logic                      clk_74a,
    input logic                      pll_core_locked,
    input logic                      cart_loading,
    input md_core_pkg::quirk_flags_t quirks,
    input md_core_pkg::region_e      region_req,
    input logic                      region_set,
    input logic                      system_reset_n,
    input md_core_pkg::bridge_addr_t bridge_addr,
    input md_core_pkg::bridge_data_t bridge_rd_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import md_core_pkg::*;

    // region change holds the system in reset
    region_holds_reset: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked) region_set |-> !system_reset_n
    ) else $error("system_reset_n high while region_set is high");

    no_quirks_loading: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked) cart_loading |-> quirks == '0
    ) else $error("quirk flags active during a cartridge load");

    region_legal: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked) region_req != 2'b11
    ) else $error("region_req holds the unused encoding");

    // only the region address reads back
    unmapped_reads_zero: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked)
            bridge_addr != addr_region |-> bridge_rd_data == '0
    ) else $error("bridge_rd_data nonzero on an unmapped address");

endmodule

bind md_core_top md_core_chk chk0 (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cart_loading   (cart_loading),
    .quirks         (quirks),
    .region_req     (region_req),
    .region_set     (region_set),
    .system_reset_n (system_reset_n),
    .bridge_addr    (bridge_addr),
    .bridge_rd_data (bridge_rd_data)
);

//--- tb_md_core.sv
/*
 * console core testbench
 * runs the command file against the top level and checks every response
 */
module tb_md_core;
    timeunit 1ns;
    timeprecision 100ps;
    import md_core_pkg::*;

    localparam string DATA_FILE = "md_core_testdata.txt";

    logic         clk_74a = 1'b0;
    logic         pll_core_locked;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    logic         osnotify_inmenu;
    logic         cart_loading;
    logic         rom_wr;
    rom_addr_t    rom_addr;
    rom_word_t    rom_data;
    key_map_t     cont_key [NUM_PADS];
    pad_t         joy [NUM_PADS];
    logic [1:0]   cpu_turbo;
    logic [1:0]   audio_filter;
    logic         multitap_en;
    logic         ar_correction_en;
    logic         composite_en;
    logic         obj_limit_high_en;
    logic         fm_en;
    logic         psg_en;
    logic         hifi_pcm_en;
    logic         fm_chip;
    quirk_flags_t quirks;
    gun_type_e    gun_type;
    gun_delay_t   gun_delay;
    region_e      region_req;
    logic         system_reset_n;

    int unsigned  cycle_count = 0;
    int unsigned  cycle_limit = 0;  // set once the command file is counted
    logic [7:0]   lfsr_state  = 8'd35;

    md_core_top dut0 (.*);

    always #4 clk_74a = ~clk_74a;

    //////////////////////////////
    // helpers

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("mismatch at %0t: %s", $time, msg));
    endtask

    always @(posedge clk_74a) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
            stop_with_failure($sformatf("timeout: no result after %0d cycles", cycle_count));
    end

    // taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bit(output logic bit_out);
        lfsr_state = lfsr_next(lfsr_state);
        bit_out    = lfsr_state[0];
    endtask

    task automatic tick();
        @(posedge clk_74a);
        #1;
    endtask

    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        tick();
        bridge_wr      = 1'b0;
    endtask

    // one word per strobe, then a few random idle cycles
    task automatic rom_write(input rom_addr_t addr, input rom_word_t word);
        logic b1;
        logic b0;
        rom_addr = addr;
        rom_data = word;
        rom_wr   = 1'b1;
        tick();
        rom_wr   = 1'b0;
        take_bit(b1);
        take_bit(b0);
        repeat ({b1, b0}) tick();
    endtask

    //////////////////////////////
    // compare tasks

    task automatic check_data(input bridge_data_t got, input bridge_data_t exp);
        if (got !== exp)
            report_mismatch($sformatf("bridge_rd_data %h, expected %h", got, exp));
    endtask

    task automatic check_pad(input int idx, input pad_t got, input pad_t exp);
        if (got !== exp)
            report_mismatch($sformatf("joy[%0d] %h, expected %h", idx, got, exp));
    endtask

    task automatic check_quirks(input quirk_flags_t got, input quirk_flags_t exp);
        if (got !== exp)
            report_mismatch($sformatf("quirks %h, expected %h", got, exp));
    endtask

    task automatic check_gun_type(input gun_type_e got, input gun_type_e exp);
        if (got !== exp)
            report_mismatch($sformatf("gun_type %0d, expected %0d", got, exp));
    endtask

    task automatic check_delay(input gun_delay_t got, input gun_delay_t exp);
        if (got !== exp)
            report_mismatch($sformatf("gun_delay %0d, expected %0d", got, exp));
    endtask

    task automatic check_region(input region_e got, input region_e exp);
        if (got !== exp)
            report_mismatch($sformatf("region_req %0d, expected %0d", got, exp));
    endtask

    task automatic check_settings(input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp)
            report_mismatch($sformatf("settings %h, expected %h", got, exp));
    endtask

    task automatic check_reset(input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("system_reset_n %b, expected %b", got, exp));
    endtask

    //////////////////////////////
    // command file

    initial begin
        int               fd;
        int               ch;
        int               n_cmds;
        logic             at_start;
        logic [7:0]       cmd;
        logic [31:0]      arg [5];
        logic [8*128-1:0] skip;

        pll_core_locked = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_wr_data  = '0;
        osnotify_inmenu = 1'b0;
        cart_loading    = 1'b0;
        rom_wr          = 1'b0;
        rom_addr        = '0;
        rom_data        = '0;
        foreach (cont_key[i])
            cont_key[i] = '0;

        // one command per line, lines starting with # do not count
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
            stop_with_failure("cannot open the command file md_core_testdata.txt");
        n_cmds   = 0;
        at_start = 1'b1;
        ch       = $fgetc(fd);
        while (ch != -1) begin
            if (at_start && ch != 35 && ch != 10)
                n_cmds++;
            at_start = (ch == 10);
            ch       = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = n_cmds * 64;

        repeat (4) @(posedge clk_74a);
        #1;
        pll_core_locked = 1'b1;

        fd = $fopen(DATA_FILE, "r");
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": void'($fgets(skip, fd));
                "W": begin
                    void'($fscanf(fd, "%h %h", arg[0], arg[1]));
                    bridge_write(arg[0], arg[1]);
                end
                "R": begin
                    void'($fscanf(fd, "%h %h", arg[0], arg[1]));
                    bridge_addr = arg[0];
                    tick();
                    check_data(bridge_rd_data, arg[1]);
                end
                "C": begin
                    void'($fscanf(fd, "%h", arg[0]));
                    check_settings({cpu_turbo, multitap_en, ar_correction_en, composite_en,
                                    obj_limit_high_en, fm_en, psg_en, hifi_pcm_en,
                                    audio_filter, fm_chip}, arg[0][11:0]);
                end
                "G": begin
                    void'($fscanf(fd, "%h", arg[0]));
                    check_region(region_req, region_e'(arg[0][1:0]));
                end
                "L": begin
                    cart_loading = 1'b1;
                    tick();
                end
                "E": begin
                    cart_loading = 1'b0;
                    tick();
                end
                "D": begin
                    void'($fscanf(fd, "%h %h", arg[0], arg[1]));
                    rom_write(arg[0][24:0], arg[1][15:0]);
                end
                "I": begin
                    void'($fscanf(fd, "%h %h %h %h %h", arg[0], arg[1], arg[2], arg[3], arg[4]));
                    for (int i = 0; i < 5; i++)
                        rom_write(HDR_ID_FIRST + rom_addr_t'(2 * i), arg[i][15:0]);
                    rom_write(HDR_ID_CHECK, 16'h0000);
                end
                "K": begin
                    void'($fscanf(fd, "%h %h %h %h", arg[0], arg[1], arg[2], arg[3]));
                    bridge_write(addr_m30_map, arg[2]);
                    cont_key[arg[0][1:0]] = arg[1][15:0];
                    repeat (3) tick();  // past the two sync stages
                    check_pad(int'(arg[0][1:0]), joy[arg[0][1:0]], arg[3][11:0]);
                end
                "Q": begin
                    void'($fscanf(fd, "%h %h %h", arg[0], arg[1], arg[2]));
                    check_quirks(quirks, arg[0][QUIRK_W-1:0]);
                    check_gun_type(gun_type, gun_type_e'(arg[1][0]));
                    check_delay(gun_delay, arg[2][7:0]);
                end
                "M": begin
                    void'($fscanf(fd, "%h", arg[0]));
                    osnotify_inmenu = arg[0][0];
                end
                "S": begin
                    void'($fscanf(fd, "%h", arg[0]));
                    check_reset(system_reset_n, arg[0][0]);
                end
                "H": while (!system_reset_n) tick();  // bounded by the cycle limit
                "N": begin
                    void'($fscanf(fd, "%h", arg[0]));
                    repeat (arg[0]) tick();
                end
                default: stop_with_failure($sformatf("unknown command %s in the command file", cmd));
            endcase
        end
        $fclose(fd);

        $display("Test passed");
        $finish;
    end

endmodule

//--- filelist.f
md_core_pkg.sv
core_settings.sv
cart_region_detect.sv
cart_quirk_lookup.sv
pad_mapper.sv
md_core_top.sv
md_core_chk.sv
tb_md_core.sv

//--- Makefile
# Verilator build and run for the console core testbench

SRCS := $(shell grep -v '^+' filelist.f)

all: run

obj_dir/Vtb_md_core: $(SRCS) filelist.f
	verilator --binary --timing --assert -f filelist.f --top-module tb_md_core

run: obj_dir/Vtb_md_core md_core_testdata.txt
	./obj_dir/Vtb_md_core > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation failed, see sim.log"; exit 1; fi
	@grep -q "Test passed" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module md_core_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- md_core_testdata.txt
# one command per line, arguments in hex
# W addr data | R addr exp | C settings | G region | L | E | D addr word | I id0..id4
# K pad keys m30 joy | Q quirks gun delay | M inmenu | S reset_n | H | N cycles
C 078
M 1
W 70 1
N 28
S 0
M 0
H
W C00000 2
W 10 1
W 40 0
W F00000 3
C 95E
R 10 0
# sram title, region E
L
I 5420 302D 3138 3732 2D36
D 1F0 2045
D 200 0000
N 4
Q 000 0 2C
G 2
R E00000 2
S 0
E
N 4
S 1
Q 001 0 2C
# lethal enforcers ii, region J
L
I 5420 392D 3135 3633 202D
D 1F0 4A20
D 200 0000
E
N 4
G 0
Q 000 1 1E
# hex region code A
L
D 1F0 2041
D 200 0000
E
N 4
R E00000 2
# unknown id, no region character
L
I 2020 2020 2020 2020 2020
D 1F0 2020
D 200 0000
E
N 4
G 1
Q 000 0 2C
K 0 0011 0 048
K 1 8340 0 E80
K 2 40A2 0 134
K 3 0C98 1 C51
K 0 0011 1 018
